// File: dataMmu.f
design/mmuPkg.sv
design/jointTlb.sv
design/tlbWriteSlave.sv
design/dataTlbStage.sv
design/dataMmu.sv
dv/dataMmu_sva.sv
dv/dataMmuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dataMmuTb
FILELIST  ?= dataMmu.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIMARGS   ?= +verilator+error+limit+100
PASSMSG   ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: dv/dataMmuTb.sv
`timescale 1ns/100ps
`default_nettype none

module dataMmuTb import mmuPkg::*; ();

    localparam int cycleLimit = 4000;    // tests take about 650 cycles
    localparam int waitLimit = 8;

    logic         clk = 1'b0;
    logic         reset;
    memReq_t      memReq;
    logic [2:0]   k0Attr;
    xlateResult_t xlate;
    logic         stall;
    wbReq_t       wb;
    logic [31:0]  wbDat;
    logic         wbAck;

    tlbEntry_t   shadow [tlbEntries];    // what software has committed
    logic [31:0] rngState = 32'd60423;
    int          lastIndex = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          errorsAtStart = 0;
    int          cycleCount = 0;

    dataMmu uut (.*);

    bind dataMmu dataMmu_sva checks (
        .clk, .reset, .stall, .bufferFlush, .ack(wbAck)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("run stopped after %0d cycles without finishing", cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // pfn in 25:6 then c in 5:3 and d and v in bits 2 and 1
    function automatic logic [31:0] packLo(input logic [19:0] pfn, input logic [2:0] c,
                                           input logic d, input logic v);
        return {6'b0, pfn, c, d, v, 1'b0};
    endfunction

    function automatic logic inShadow(input logic [18:0] vpn2);
        for (int i = 0; i < tlbEntries; i++) begin
            if (shadow[i].present && shadow[i].vpn2 == vpn2) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic tlbEntry_t randomEntry(input logic [18:0] vpn2);
        tlbEntry_t   e;
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = xorshift();
        r1 = xorshift();
        e = '{present: 1'b1, vpn2: vpn2, pfn0: r0[19:0], c0: r0[22:20], d0: 1'b1, v0: 1'b1,
              pfn1: r1[19:0], c1: r1[22:20], d1: 1'b1, v1: 1'b1};
        return e;
    endfunction

    function automatic xlateResult_t expectXlate(input tlbEntry_t tbl [tlbEntries],
                                                 input logic [2:0] k0, input memReq_t req);
        xlateResult_t res;
        tlbEntry_t    hit;
        logic         found;
        logic [3:0]   seg;
        logic [2:0]   pageC;
        res = '0;
        hit = '0;
        found = 1'b0;
        seg = req.vpn[19:16];
        if (seg inside {4'h8, 4'h9, 4'hA, 4'hB}) begin
            res.pfn = {3'b000, req.vpn[16:0]};    // physical = virtual & 1fffffff
            res.uncached = (seg >= 4'hA) || (k0 != cacheableAttr);
        end else begin
            for (int i = 0; i < tlbEntries; i++) begin
                if (!found && tbl[i].present && tbl[i].vpn2 == req.vpn[19:1]) begin
                    hit = tbl[i];
                    found = 1'b1;
                end
            end
            res.pfn = req.vpn[0] ? hit.pfn1 : hit.pfn0;
            pageC = req.vpn[0] ? hit.c1 : hit.c0;
            res.uncached = (pageC != cacheableAttr);
            if (!found) begin
                res.exc = req.read ? rdRefill : wrRefill;
            end else if (!(req.vpn[0] ? hit.v1 : hit.v0)) begin
                res.exc = req.read ? rdInvalid : wrInvalid;
            end else if (req.store && !(req.vpn[0] ? hit.d1 : hit.d0)) begin
                res.exc = modified;
            end
        end
        res.ex = (res.exc != noEx);
        return res;
    endfunction

    // every settled, active request is compared against the shadow table
    always @(posedge clk) begin
        xlateResult_t want;
        if (!reset && (memReq.read || memReq.store) && !stall) begin
            want = expectXlate(shadow, k0Attr, memReq);
            checkCount++;
            assert (xlate.exc == want.exc && xlate.ex == want.ex) else begin
                $display("Error: xlate.exc = %h, expected %h (vpn %h)",
                         xlate.exc, want.exc, memReq.vpn);
                errorCount++;
            end
            if (want.exc != rdRefill && want.exc != wrRefill) begin
                assert (xlate.pfn == want.pfn) else begin
                    $display("Error: xlate.pfn = %h, expected %h", xlate.pfn, want.pfn);
                    errorCount++;
                end
                assert (xlate.uncached == want.uncached) else begin
                    $display("Error: xlate.uncached = %h, expected %h",
                             xlate.uncached, want.uncached);
                    errorCount++;
                end
            end
        end
    end

    task automatic busWrite(input wbReg_t adr, input logic [31:0] dat);
        int waitCycles;
        @(negedge clk);
        wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        waitCycles = 0;
        @(posedge clk);
        while (!wbAck && waitCycles < waitLimit) begin
            waitCycles++;
            @(posedge clk);
        end
        assert (wbAck) else begin
            $display("Wishbone write to register %0d got no acknowledge", adr);
            errorCount++;
        end
        @(negedge clk);
        wb = '0;
    endtask

    task automatic busRead(input wbReg_t adr, output logic [31:0] dat);
        int waitCycles;
        @(negedge clk);
        wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'b0};
        waitCycles = 0;
        @(posedge clk);
        while (!wbAck && waitCycles < waitLimit) begin
            waitCycles++;
            @(posedge clk);
        end
        dat = wbDat;
        assert (wbAck) else begin
            $display("Wishbone read of register %0d got no acknowledge", adr);
            errorCount++;
        end
        @(negedge clk);
        wb = '0;
    endtask

    task automatic writeEntry(input int idx, input tlbEntry_t e);
        busWrite(regEntryHi, {e.vpn2, 13'b0});
        busWrite(regEntryLo0, packLo(e.pfn0, e.c0, e.d0, e.v0));
        busWrite(regEntryLo1, packLo(e.pfn1, e.c1, e.d1, e.v1));
        busWrite(regIndex, 32'(idx));    // commit and flush
        shadow[idx] = e;
        shadow[idx].present = 1'b1;
        lastIndex = idx;
    endtask

    // wantStall below zero means the stall length is not checked
    task automatic access(input logic [19:0] vpn, input logic isStore, input int wantStall);
        int stallCycles;
        @(negedge clk);
        memReq = '{vpn: vpn, read: !isStore, store: isStore};
        stallCycles = 0;
        @(posedge clk);
        while (stall && stallCycles < waitLimit) begin
            stallCycles++;
            @(posedge clk);
        end
        assert (stallCycles < waitLimit) else begin
            $display("stall never dropped for vpn %h", vpn);
            errorCount++;
        end
        assert (wantStall < 0 || stallCycles == wantStall) else begin
            $display("Error: stall cycles = %h, expected %h", stallCycles, wantStall);
            errorCount++;
        end
        @(negedge clk);
        memReq.read = 1'b0;
        memReq.store = 1'b0;
    endtask

    task automatic expectReg(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got == want) else begin
            $display("Error: wbDat (%s) = %h, expected %h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name);
        $display("test %s done, %0d errors", name, errorCount - errorsAtStart);
        errorsAtStart = errorCount;
    endtask

    initial begin
        tlbEntry_t   e;
        logic [31:0] r;
        logic [31:0] got;
        logic [18:0] vpn2;
        logic [18:0] vpn2s [tlbEntries];
        reset = 1'b1;
        memReq = '0;
        k0Attr = '0;
        wb = '0;
        for (int i = 0; i < tlbEntries; i++) shadow[i] = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 40; i++) begin
            r = xorshift();
            k0Attr = i[0] ? cacheableAttr : r[26:24];
            access({2'b10, r[1:0], r[17:2]}, r[20], 0);    // kseg0 and kseg1
        end
        reportTest("unmapped");

        for (int i = 0; i < tlbEntries; i++) begin
            r = xorshift();
            vpn2s[i] = {1'b0, r[17:0]};    // kuseg
            writeEntry(i, randomEntry(vpn2s[i]));
        end
        for (int i = 0; i < tlbEntries; i++) begin
            r = xorshift();
            access({vpn2s[i], r[0]}, 1'b0, 2);
            access({vpn2s[i], !r[0]}, r[1], 0);    // other page of the same pair
        end
        reportTest("refill and hit");

        for (int i = 0; i < 12; i++) begin
            do begin
                r = xorshift();
                vpn2 = {1'b0, r[17:0]};
            end while (inShadow(vpn2));
            access({vpn2, r[18]}, i[0], -1);
        end
        reportTest("refill exceptions");

        for (int k = 0; k < 4; k++) begin
            r = xorshift();
            e = randomEntry({1'b0, r[17:0]});
            e.v0 = 1'b0;
            e.d1 = 1'b0;
            writeEntry(k, e);
            access({e.vpn2, 1'b0}, 1'b0, 2);
            access({e.vpn2, 1'b0}, 1'b1, 0);
            access({e.vpn2, 1'b1}, 1'b1, 0);
            access({e.vpn2, 1'b1}, 1'b0, 0);
        end
        reportTest("invalid and modified");

        for (int idx = 8; idx < 12; idx++) begin
            access({vpn2s[idx], 1'b0}, 1'b0, -1);
            writeEntry(idx, randomEntry(vpn2s[idx]));
            access({vpn2s[idx], 1'b0}, 1'b0, 2);    // must show the new pfn
        end
        reportTest("flush");

        r = xorshift();
        e = randomEntry(r[18:0]);
        e.v0 = r[0];
        e.d1 = r[1];
        busWrite(regEntryHi, {e.vpn2, r[31:19]});    // low bits are not stored
        busWrite(regEntryLo0, packLo(e.pfn0, e.c0, e.d0, e.v0) | 32'hFC000001);
        busWrite(regEntryLo1, packLo(e.pfn1, e.c1, e.d1, e.v1) | 32'hFC000001);
        busRead(regEntryHi, got);
        expectReg("entryHi", got, {e.vpn2, 13'b0});
        busRead(regEntryLo0, got);
        expectReg("entryLo0", got, packLo(e.pfn0, e.c0, e.d0, e.v0));
        busRead(regEntryLo1, got);
        expectReg("entryLo1", got, packLo(e.pfn1, e.c1, e.d1, e.v1));
        busRead(regIndex, got);
        expectReg("index", got, 32'(lastIndex));
        reportTest("register readback");

        errorCount += uut.checks.failCount;
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/dataMmu_sva.sv
`timescale 1ns/100ps
`default_nettype none

module dataMmu_sva (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic bufferFlush,
    input logic ack
);

    int failCount = 0;

    // a held miss stalls through idle and fetch and then releases
    stallTwoCycles: assert property (
        @(posedge clk) disable iff (reset || bufferFlush)
        $rose(stall) |=> stall ##1 !stall
    ) else begin
        failCount++;
        $error("stall did not last exactly two cycles");
    end

    ackSingleCycle: assert property (
        @(posedge clk) disable iff (reset)
        ack |=> !ack
    ) else begin
        failCount++;
        $error("Wishbone ack was high for two cycles in a row");
    end

    noUnknowns: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown({stall, ack})
    ) else begin
        failCount++;
        $error("stall or ack is unknown after reset");
    end

endmodule

`default_nettype wire

// File: design/dataMmu.sv
`timescale 1ns/100ps
`default_nettype none

module dataMmu import mmuPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  memReq_t      memReq,
    input  logic [2:0]   k0Attr,
    output xlateResult_t xlate,
    output logic         stall,
    input  wbReq_t       wb,
    output logic [31:0]  wbDat,
    output logic         wbAck
);

    logic                    tlbWrite;
    logic [tlbIndexBits-1:0] tlbWrIndex;
    tlbEntry_t               tlbWrEntry;
    logic                    bufferFlush;
    logic [18:0]             lookupVpn2;
    tlbLookup_t              lookup;

    tlbWriteSlave writeSlave (
        .clk, .reset,
        .wb, .wbDat, .wbAck,
        .tlbWrite, .tlbWrIndex, .tlbWrEntry,
        .bufferFlush
    );

    jointTlb jtlb (
        .clk, .reset,
        .lookupVpn2, .lookup,
        .tlbWrite, .tlbWrIndex, .tlbWrEntry
    );

    dataTlbStage dtlb (
        .clk, .reset,
        .memReq, .k0Attr, .bufferFlush,
        .lookup, .lookupVpn2,
        .xlate, .stall
    );

endmodule

`default_nettype wire

// File: design/dataTlbStage.sv
`timescale 1ns/100ps
`default_nettype none

module dataTlbStage import mmuPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  memReq_t      memReq,
    input  logic [2:0]   k0Attr,
    input  logic         bufferFlush,
    input  tlbLookup_t   lookup,
    output logic [18:0]  lookupVpn2,
    output xlateResult_t xlate,
    output logic         stall
);

    refillState_t state;
    refillState_t nextState;

    logic        bufValid;
    logic        bufFound;
    tlbEntry_t   bufEntry;
    logic [18:0] bufVpn2;

    logic [3:0]  seg;
    logic        kseg0;
    logic        kseg1;
    logic        unmapped;
    logic        active;
    logic        bufHit;
    logic        oddPage;
    logic [19:0] pagePfn;
    logic [2:0]  pageC;
    logic        pageD;
    logic        pageV;
    excCode_t    excCode;

    assign seg      = memReq.vpn[19:16];    // address bits 31:28
    assign kseg0    = (seg == 4'h8) || (seg == 4'h9);
    assign kseg1    = (seg == 4'hA) || (seg == 4'hB);
    assign unmapped = kseg0 || kseg1;
    assign active   = memReq.read || memReq.store;
    assign oddPage  = memReq.vpn[0];

    assign lookupVpn2 = memReq.vpn[19:1];
    assign bufHit     = bufValid && (bufVpn2 == lookupVpn2);
    assign stall      = !unmapped && active && !bufHit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (stall) nextState = fetch;
            end
            fetch: begin
                if (!bufferFlush) nextState = idle;    // flush forces another fetch
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || bufferFlush) begin
            bufValid <= 1'b0;
        end else if (state == fetch) begin
            bufValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch && !bufferFlush) begin
            bufFound <= lookup.found;
            bufEntry <= lookup.entry;
            bufVpn2  <= lookupVpn2;    // kept even on a miss, for refill exceptions
        end
    end

    // even or odd page of the buffered pair
    always_comb begin
        if (oddPage) begin
            pagePfn = bufEntry.pfn1;
            pageC   = bufEntry.c1;
            pageD   = bufEntry.d1;
            pageV   = bufEntry.v1;
        end else begin
            pagePfn = bufEntry.pfn0;
            pageC   = bufEntry.c0;
            pageD   = bufEntry.d0;
            pageV   = bufEntry.v0;
        end
    end

    always_comb begin
        excCode = noEx;
        if (!unmapped && active && bufHit) begin
            if (!bufFound) begin
                excCode = memReq.read ? rdRefill : wrRefill;
            end else if (!pageV) begin
                excCode = memReq.read ? rdInvalid : wrInvalid;
            end else if (memReq.store && !pageD) begin
                excCode = modified;
            end
        end
    end

    always_comb begin
        if (kseg1) begin
            xlate.pfn      = {3'b000, memReq.vpn[16:0]};
            xlate.uncached = 1'b1;
        end else if (kseg0) begin
            xlate.pfn      = {1'b0, memReq.vpn[18:0]};
            xlate.uncached = (k0Attr != cacheableAttr);
        end else begin
            xlate.pfn      = pagePfn;
            xlate.uncached = (pageC != cacheableAttr);
        end
        xlate.exc = excCode;
        xlate.ex  = (excCode != noEx);
    end

endmodule

`default_nettype wire

// File: design/tlbWriteSlave.sv
`timescale 1ns/100ps
`default_nettype none

module tlbWriteSlave import mmuPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  wbReq_t                  wb,
    output logic [31:0]             wbDat,
    output logic                    wbAck,
    output logic                    tlbWrite,
    output logic [tlbIndexBits-1:0] tlbWrIndex,
    output tlbEntry_t               tlbWrEntry,
    output logic                    bufferFlush
);

    wbReg_t regSel;
    logic   wbWrite;

    logic [31:13]            hiBits;     // vpn2
    logic [25:1]             lo0Bits;    // pfn, c, d, v
    logic [25:1]             lo1Bits;
    logic [tlbIndexBits-1:0] indexReg;

    assign regSel  = wbReg_t'(wb.adr);
    assign wbWrite = wbAck && wb.cyc && wb.stb && wb.we;

    // single-cycle ack, one cycle after the strobe is seen
    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= wb.cyc && wb.stb && !wbAck;
        end
    end

    always_ff @(posedge clk) begin
        if (wbWrite) begin
            case (regSel)
                regEntryHi:  hiBits   <= wb.dat[31:13];
                regEntryLo0: lo0Bits  <= wb.dat[25:1];
                regEntryLo1: lo1Bits  <= wb.dat[25:1];
                regIndex:    indexReg <= wb.dat[tlbIndexBits-1:0];
            endcase
        end
    end

    always_comb begin
        case (regSel)
            regEntryHi:  wbDat = {hiBits, 13'b0};
            regEntryLo0: wbDat = {6'b0, lo0Bits, 1'b0};
            regEntryLo1: wbDat = {6'b0, lo1Bits, 1'b0};
            regIndex:    wbDat = {{(32 - tlbIndexBits){1'b0}}, indexReg};
        endcase
    end

    // commit uses the index being written, not the old one
    assign tlbWrite    = wbWrite && (regSel == regIndex);
    assign bufferFlush = tlbWrite;
    assign tlbWrIndex  = wb.dat[tlbIndexBits-1:0];

    always_comb begin
        tlbWrEntry.present = 1'b1;
        tlbWrEntry.vpn2    = hiBits;
        tlbWrEntry.pfn0    = lo0Bits[25:6];
        tlbWrEntry.c0      = lo0Bits[5:3];
        tlbWrEntry.d0      = lo0Bits[2];
        tlbWrEntry.v0      = lo0Bits[1];
        tlbWrEntry.pfn1    = lo1Bits[25:6];
        tlbWrEntry.c1      = lo1Bits[5:3];
        tlbWrEntry.d1      = lo1Bits[2];
        tlbWrEntry.v1      = lo1Bits[1];
    end

endmodule

`default_nettype wire

// File: design/jointTlb.sv
`timescale 1ns/100ps
`default_nettype none

module jointTlb import mmuPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [18:0]             lookupVpn2,
    output tlbLookup_t              lookup,
    input  logic                    tlbWrite,
    input  logic [tlbIndexBits-1:0] tlbWrIndex,
    input  tlbEntry_t               tlbWrEntry
);

    tlbEntry_t entries [tlbEntries];
    logic [tlbEntries-1:0] matchVec;
    logic [tlbIndexBits-1:0] hitIdx;

    // only the present bits are cleared, the rest is plain storage
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlbEntries; i++) begin
                entries[i].present <= 1'b0;
            end
        end else if (tlbWrite) begin
            entries[tlbWrIndex] <= tlbWrEntry;
        end
    end

    // compare against all entries at once
    always_comb begin
        for (int i = 0; i < tlbEntries; i++) begin
            matchVec[i] = entries[i].present && (entries[i].vpn2 == lookupVpn2);
        end
    end

    // scan downward so the lowest match is the last one kept
    always_comb begin
        hitIdx = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (matchVec[i]) begin
                hitIdx = tlbIndexBits'(i);
            end
        end
    end

    always_comb begin
        lookup.found = |matchVec;
        lookup.entry = entries[hitIdx];    // don't care when not found
    end

endmodule

`default_nettype wire

// File: design/mmuPkg.sv
`default_nettype none

package mmuPkg;

    localparam int tlbEntries = 16;
    localparam int tlbIndexBits = 4;
    localparam logic [2:0] cacheableAttr = 3'd3;    // only this code is cached
    localparam int wbAdrBits = 2;

    typedef enum logic [2:0] {
        noEx      = 3'd0,
        rdRefill  = 3'd1,
        wrRefill  = 3'd2,
        rdInvalid = 3'd3,
        wrInvalid = 3'd4,
        modified  = 3'd5
    } excCode_t;

    typedef enum logic {
        idle  = 1'b0,
        fetch = 1'b1
    } refillState_t;

    typedef enum logic [wbAdrBits-1:0] {
        regEntryHi  = 2'd0,
        regEntryLo0 = 2'd1,
        regEntryLo1 = 2'd2,
        regIndex    = 2'd3
    } wbReg_t;

    // one pair of 4 KB pages per entry
    typedef struct packed {
        logic        present;
        logic [18:0] vpn2;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlbEntry_t;

    typedef struct packed {
        logic      found;
        tlbEntry_t entry;
    } tlbLookup_t;

    typedef struct packed {
        logic [19:0] vpn;    // address bits 31:12
        logic        read;
        logic        store;
    } memReq_t;

    typedef struct packed {
        logic [19:0] pfn;
        logic        uncached;
        excCode_t    exc;
        logic        ex;
    } xlateResult_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [wbAdrBits-1:0] adr;
        logic [31:0]          dat;
    } wbReq_t;

endpackage

`default_nettype wire
